/* verilog/router_pkg.sv */
// ====================
// router shared definitions
// widths, port and channel enums, flit type
// ====================
package router_pkg;

    // ====================
    // widths
    // ====================

    // one flit on every link and in every buffer entry
    localparam int FLIT_W    = 64;
    // signed hop offset, one for X and one for Y
    localparam int HOP_W     = 4;
    // four mesh neighbours plus the local PE
    localparam int NUM_PORTS = 5;

    // ====================
    // types
    // ====================

    typedef logic [FLIT_W-1:0] flit_t;

    // port index, also the bit order of every per-port vector
    typedef enum logic [2:0] {
        PORT_UP    = 3'd0,
        PORT_DOWN  = 3'd1,
        PORT_LEFT  = 3'd2,
        PORT_RIGHT = 3'd3,
        PORT_PE    = 3'd4
    } port_e;

    // one bit per port
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // time-multiplexed virtual channel
    // polarity names the internal channel, the other one is external
    typedef enum logic {
        VC_EVEN = 1'b0,
        VC_ODD  = 1'b1
    } vc_e;

endpackage

/* verilog/input_vc_buffer.sv */
// ====================
// input channel buffer
// one flit entry per virtual channel on a router input
// ====================
`timescale 1ns/1ps

module input_vc_buffer (
    input  logic              clk,
    input  logic              reset,
    input  router_pkg::vc_e   polarity_i,
    input  logic              send_i,
    input  router_pkg::flit_t data_i,
    input  logic              clear_i [2],
    output logic              ready_o,
    output router_pkg::flit_t data_o  [2],
    output logic              valid_o [2]
);
    import router_pkg::*;

    vc_e   ext_vc;
    logic  accept;
    logic  valid_q [2];
    flit_t data_q  [2];

    // the link side always talks to the channel that is not internal
    assign ext_vc  = (polarity_i == VC_EVEN) ? VC_ODD : VC_EVEN;
    assign ready_o = ~valid_q[ext_vc];
    assign accept  = send_i & ready_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q[VC_EVEN] <= 1'b0;
            valid_q[VC_ODD]  <= 1'b0;
        end else begin
            // clears only come for the internal channel
            for (int c = 0; c < 2; c++) begin
                if (clear_i[c]) valid_q[c] <= 1'b0;
            end
            if (accept) valid_q[ext_vc] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) data_q[ext_vc] <= data_i;
    end

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            data_o[c]  = data_q[c];
            valid_o[c] = valid_q[c];
        end
    end

endmodule

/* verilog/rr_arbiter.sv */
// ====================
// round-robin arbiter
// five requesters, one-hot pointer and grant
// ====================
`timescale 1ns/1ps

module rr_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  en_i,
    input  logic                  free_i,
    input  router_pkg::port_vec_t req_i,
    output router_pkg::port_vec_t gnt_o
);
    import router_pkg::*;

    // set bit marks the requester searched first
    port_vec_t              ptr_q;
    logic [2*NUM_PORTS-1:0] req_dbl;
    logic [2*NUM_PORTS-1:0] gnt_dbl;

    // requests repeated so the upward search wraps past PORT_PE
    assign req_dbl = {req_i, req_i};

    // isolates the lowest request at or above the pointer position
    assign gnt_dbl = req_dbl & ~(req_dbl - {{NUM_PORTS{1'b0}}, ptr_q});

    // fold both halves back onto the five requesters
    assign gnt_o = (en_i && free_i)
                 ? (gnt_dbl[NUM_PORTS-1:0] | gnt_dbl[2*NUM_PORTS-1:NUM_PORTS])
                 : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            // start at PORT_UP
            ptr_q <= port_vec_t'(1);
        end else if (gnt_o != '0) begin
            // winner drops to lowest priority
            ptr_q <= {gnt_o[NUM_PORTS-2:0], gnt_o[NUM_PORTS-1]};
        end
    end

endmodule

/* verilog/vc_switch_alloc.sv */
// ====================
// switch allocator for one virtual channel
// XY route decode, per-output round-robin arbitration,
// output write and input clear steering
// ====================
`timescale 1ns/1ps

module vc_switch_alloc #(
    parameter int              HOP_X_LSB = 52,
    parameter int              HOP_Y_LSB = 48,
    parameter router_pkg::vc_e ALLOC_VC  = router_pkg::VC_EVEN
) (
    input  logic                  clk,
    input  logic                  reset,
    input  router_pkg::vc_e       polarity_i,
    input  router_pkg::flit_t     in_data_i     [router_pkg::NUM_PORTS],
    input  router_pkg::port_vec_t in_valid_i,
    input  router_pkg::port_vec_t out_empty_i,
    output router_pkg::port_vec_t out_wr_en_o,
    output router_pkg::flit_t     out_wr_data_o [router_pkg::NUM_PORTS],
    output router_pkg::port_vec_t in_clear_o
);
    import router_pkg::*;

    localparam logic signed [HOP_W-1:0] HOP_ONE = 1;

    logic      active;
    port_e     tgt [NUM_PORTS];
    flit_t     upd [NUM_PORTS];
    port_vec_t req [NUM_PORTS];
    port_vec_t gnt [NUM_PORTS];

    // this channel owns the switch only in its own phase
    assign active = (polarity_i == ALLOC_VC);

    // ====================
    // route decode
    // ====================

    // X first, then Y; the offset used steps one unit toward zero
    always_comb begin
        logic signed [HOP_W-1:0] x_off;
        logic signed [HOP_W-1:0] y_off;

        for (int i = 0; i < NUM_PORTS; i++) begin
            x_off  = in_data_i[i][HOP_X_LSB +: HOP_W];
            y_off  = in_data_i[i][HOP_Y_LSB +: HOP_W];
            upd[i] = in_data_i[i];
            if (x_off[HOP_W-1]) begin
                tgt[i] = PORT_LEFT;
                upd[i][HOP_X_LSB +: HOP_W] = x_off + HOP_ONE;
            end else if (x_off != '0) begin
                tgt[i] = PORT_RIGHT;
                upd[i][HOP_X_LSB +: HOP_W] = x_off - HOP_ONE;
            end else if (y_off[HOP_W-1]) begin
                tgt[i] = PORT_UP;
                upd[i][HOP_Y_LSB +: HOP_W] = y_off + HOP_ONE;
            end else if (y_off != '0) begin
                tgt[i] = PORT_DOWN;
                upd[i][HOP_Y_LSB +: HOP_W] = y_off - HOP_ONE;
            end else begin
                // arrived, flit goes to the PE untouched
                tgt[i] = PORT_PE;
            end
        end
    end

    // one request vector per output, bit i set by input i
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                req[o][i] = in_valid_i[i] && (tgt[i] == port_e'(o));
            end
        end
    end

    // ====================
    // arbitration
    // ====================

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_arb
        rr_arbiter u_arb (
            .clk    (clk),
            .reset  (reset),
            .en_i   (active),
            .free_i (out_empty_i[o]),
            .req_i  (req[o]),
            .gnt_o  (gnt[o])
        );
    end

    // ====================
    // write and clear steering
    // ====================

    // grants are one-hot and already gated by the phase
    always_comb begin
        out_wr_en_o = '0;
        in_clear_o  = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_wr_data_o[o] = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (gnt[o][i]) begin
                    out_wr_en_o[o]   = 1'b1;
                    out_wr_data_o[o] = upd[i];
                    in_clear_o[i]    = 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/output_vc_buffer.sv */
// ====================
// output channel buffer
// one flit entry per virtual channel, filled by the allocators,
// drained onto the link on the external phase
// ====================
`timescale 1ns/1ps

module output_vc_buffer (
    input  logic              clk,
    input  logic              reset,
    input  router_pkg::vc_e   polarity_i,
    input  logic              wr_en_i   [2],
    input  router_pkg::flit_t wr_data_i [2],
    input  logic              ready_i,
    output logic              empty_o   [2],
    output logic              send_o,
    output router_pkg::flit_t data_o
);
    import router_pkg::*;

    vc_e   ext_vc;
    logic  valid_q [2];
    flit_t data_q  [2];

    assign ext_vc = (polarity_i == VC_EVEN) ? VC_ODD : VC_EVEN;

    // link side shows the external entry
    assign send_o = valid_q[ext_vc] & ready_i;
    assign data_o = data_q[ext_vc];

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            empty_o[c] = ~valid_q[c];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q[VC_EVEN] <= 1'b0;
            valid_q[VC_ODD]  <= 1'b0;
        end else begin
            // drain hits the external entry, writes only the internal one
            if (send_o) valid_q[ext_vc] <= 1'b0;
            for (int c = 0; c < 2; c++) begin
                if (wr_en_i[c]) valid_q[c] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < 2; c++) begin
            if (wr_en_i[c]) data_q[c] <= wr_data_i[c];
        end
    end

endmodule

/* verilog/mesh_router.sv */
// ====================
// five-port mesh router
// even and odd virtual channels alternate between switch and link
// ====================
`timescale 1ns/1ps

module mesh_router #(
    parameter int HOP_X_LSB = 52,
    parameter int HOP_Y_LSB = 48
) (
    input  logic                  clk,
    input  logic                  reset,
    input  router_pkg::port_vec_t send_i,
    input  router_pkg::flit_t     data_i [router_pkg::NUM_PORTS],
    input  router_pkg::port_vec_t ready_i,
    output router_pkg::port_vec_t ready_o,
    output router_pkg::port_vec_t send_o,
    output router_pkg::flit_t     data_o [router_pkg::NUM_PORTS],
    output router_pkg::vc_e       polarity_o
);
    import router_pkg::*;

    // buffer side, indexed [port][channel]
    logic  ib_valid   [NUM_PORTS][2];
    flit_t ib_data    [NUM_PORTS][2];
    logic  ib_clear   [NUM_PORTS][2];
    logic  ob_empty   [NUM_PORTS][2];
    logic  ob_wr_en   [NUM_PORTS][2];
    flit_t ob_wr_data [NUM_PORTS][2];

    // allocator side, indexed [channel][port]
    port_vec_t in_valid    [2];
    flit_t     in_data     [2][NUM_PORTS];
    port_vec_t in_clear    [2];
    port_vec_t out_empty   [2];
    port_vec_t out_wr_en   [2];
    flit_t     out_wr_data [2][NUM_PORTS];

    // phase register, even channel is internal first
    always_ff @(posedge clk) begin
        if (reset) begin
            polarity_o <= VC_EVEN;
        end else begin
            polarity_o <= (polarity_o == VC_EVEN) ? VC_ODD : VC_EVEN;
        end
    end

    // ====================
    // per-port buffers
    // ====================

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        input_vc_buffer u_in (
            .clk        (clk),
            .reset      (reset),
            .polarity_i (polarity_o),
            .send_i     (send_i[p]),
            .data_i     (data_i[p]),
            .clear_i    (ib_clear[p]),
            .ready_o    (ready_o[p]),
            .data_o     (ib_data[p]),
            .valid_o    (ib_valid[p])
        );

        output_vc_buffer u_out (
            .clk        (clk),
            .reset      (reset),
            .polarity_i (polarity_o),
            .wr_en_i    (ob_wr_en[p]),
            .wr_data_i  (ob_wr_data[p]),
            .ready_i    (ready_i[p]),
            .empty_o    (ob_empty[p]),
            .send_o     (send_o[p]),
            .data_o     (data_o[p])
        );

        // regroup per-port channel pairs into per-channel port sets
        for (genvar c = 0; c < 2; c++) begin : g_vc
            assign in_valid[c][p]   = ib_valid[p][c];
            assign in_data[c][p]    = ib_data[p][c];
            assign ib_clear[p][c]   = in_clear[c][p];
            assign out_empty[c][p]  = ob_empty[p][c];
            assign ob_wr_en[p][c]   = out_wr_en[c][p];
            assign ob_wr_data[p][c] = out_wr_data[c][p];
        end
    end

    // ====================
    // switch allocators
    // ====================

    vc_switch_alloc #(
        .HOP_X_LSB (HOP_X_LSB),
        .HOP_Y_LSB (HOP_Y_LSB),
        .ALLOC_VC  (VC_EVEN)
    ) u_alloc_even (
        .clk           (clk),
        .reset         (reset),
        .polarity_i    (polarity_o),
        .in_data_i     (in_data[VC_EVEN]),
        .in_valid_i    (in_valid[VC_EVEN]),
        .out_empty_i   (out_empty[VC_EVEN]),
        .out_wr_en_o   (out_wr_en[VC_EVEN]),
        .out_wr_data_o (out_wr_data[VC_EVEN]),
        .in_clear_o    (in_clear[VC_EVEN])
    );

    vc_switch_alloc #(
        .HOP_X_LSB (HOP_X_LSB),
        .HOP_Y_LSB (HOP_Y_LSB),
        .ALLOC_VC  (VC_ODD)
    ) u_alloc_odd (
        .clk           (clk),
        .reset         (reset),
        .polarity_i    (polarity_o),
        .in_data_i     (in_data[VC_ODD]),
        .in_valid_i    (in_valid[VC_ODD]),
        .out_empty_i   (out_empty[VC_ODD]),
        .out_wr_en_o   (out_wr_en[VC_ODD]),
        .out_wr_data_o (out_wr_data[VC_ODD]),
        .in_clear_o    (in_clear[VC_ODD])
    );

endmodule

/* tests/mesh_router_assert.sv */
// ====================
// link protocol checks for the mesh router
// bound to every mesh_router instance
// ====================
`timescale 1ns/1ps

module mesh_router_assert (
    input logic                  clk,
    input logic                  reset,
    input router_pkg::port_vec_t send_o,
    input router_pkg::port_vec_t ready_i,
    input router_pkg::port_vec_t ready_o,
    input router_pkg::vc_e       polarity_o
);

    // a send only goes to a ready neighbour
    a_send_needs_ready: assert property (
        @(posedge clk) disable iff (reset)
        (send_o & ~ready_i) == '0
    ) else $error("send_o high on a port whose ready_i is low");

    // phase alternates on every clock once out of reset
    a_polarity_toggles: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> polarity_o != $past(polarity_o)
    ) else $error("polarity_o did not toggle");

    // idle links in the first cycle after reset
    a_reset_state: assert property (
        @(posedge clk)
        $fell(reset) |-> (ready_o == '1 && send_o == '0)
    ) else $error("ready_o or send_o wrong in the first cycle after reset");

endmodule

bind mesh_router mesh_router_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .send_o     (send_o),
    .ready_i    (ready_i),
    .ready_o    (ready_o),
    .polarity_o (polarity_o)
);

/* tests/mesh_router_tb.sv */
// ====================
// mesh router testbench
// table-driven flits on all ports, checked against the XY rule
// ====================
`timescale 1ns/1ps

module mesh_router_tb;
    import router_pkg::*;

    localparam int X_LSB = 52;
    localparam int Y_LSB = 48;

    typedef struct packed {
        port_e src;
        flit_t flit;
        port_e dst;
        flit_t exp;
    } row_t;

    logic      clk;
    logic      reset;
    port_vec_t send_i;
    flit_t     data_i [NUM_PORTS];
    port_vec_t ready_i;
    port_vec_t ready_o;
    port_vec_t send_o;
    flit_t     data_o [NUM_PORTS];
    vc_e       polarity_o;

    row_t  rows     [$];
    port_e arr_port [$];
    flit_t arr_flit [$];
    int    value_errors;
    int    other_errors;
    int    first;
    int    cycles;
    vc_e   rr_vc;
    vc_e   bp_vc;

    mesh_router dut_i (
        .clk        (clk),
        .reset      (reset),
        .send_i     (send_i),
        .data_i     (data_i),
        .ready_i    (ready_i),
        .ready_o    (ready_o),
        .send_o     (send_o),
        .data_o     (data_o),
        .polarity_o (polarity_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // send_o is stable from just after the edge, so every transfer is seen here
    always @(negedge clk) begin
        if (!reset) begin
            for (int q = 0; q < NUM_PORTS; q++) begin
                if (send_o[q]) begin
                    arr_port.push_back(port_e'(3'(q)));
                    arr_flit.push_back(data_o[q]);
                end
            end
        end
    end

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_port(input string name, input port_e got, input port_e exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_vec(input string name, input port_vec_t got, input port_vec_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    // XY rule: X first, the offset used steps one unit toward zero
    function automatic void route(input flit_t f, output port_e dst, output flit_t exp);
        logic [HOP_W-1:0] x;
        logic [HOP_W-1:0] y;
        x   = f[X_LSB +: HOP_W];
        y   = f[Y_LSB +: HOP_W];
        exp = f;
        if (x[HOP_W-1]) begin
            dst = PORT_LEFT;
            exp[X_LSB +: HOP_W] = x + 1'b1;
        end else if (x != '0) begin
            dst = PORT_RIGHT;
            exp[X_LSB +: HOP_W] = x - 1'b1;
        end else if (y[HOP_W-1]) begin
            dst = PORT_UP;
            exp[Y_LSB +: HOP_W] = y + 1'b1;
        end else if (y != '0) begin
            dst = PORT_DOWN;
            exp[Y_LSB +: HOP_W] = y - 1'b1;
        end else begin
            dst = PORT_PE;
        end
    endfunction

    // random filler, hop offsets in place, row number as tag in the low byte
    task automatic add_row(input port_e src, input int x, input int y);
        row_t  r;
        port_e dst;
        flit_t exp;
        r.src  = src;
        r.flit = {$urandom, $urandom};
        r.flit[X_LSB +: HOP_W] = x[HOP_W-1:0];
        r.flit[Y_LSB +: HOP_W] = y[HOP_W-1:0];
        r.flit[7:0] = 8'(rows.size());
        route(r.flit, dst, exp);
        r.dst = dst;
        r.exp = exp;
        rows.push_back(r);
    endtask

    // all rows of the burst go in on the same edge
    task automatic inject(input int first_row, input int n);
        port_vec_t mask;
        int        wait_n;
        mask   = '0;
        wait_n = 0;
        for (int i = first_row; i < first_row + n; i++) begin
            mask[rows[i].src] = 1'b1;
        end
        while ((ready_o & mask) != mask && wait_n < 8) begin
            @(posedge clk);
            #1;
            wait_n++;
        end
        if ((ready_o & mask) != mask) begin
            other_errors++;
            $display("timeout waiting for ready_o on ports %b", mask);
        end
        for (int i = first_row; i < first_row + n; i++) begin
            data_i[rows[i].src] = rows[i].flit;
            send_i[rows[i].src] = 1'b1;
        end
        @(posedge clk);
        #1;
        send_i = '0;
    endtask

    // waits up to limit edges for n arrivals, then compares them in order
    task automatic score(input int first_row, input int n, input int limit);
        int    wait_n;
        port_e got_port;
        flit_t got_flit;
        wait_n = 0;
        while (arr_port.size() < n && wait_n < limit) begin
            @(posedge clk);
            #1;
            wait_n++;
        end
        for (int i = first_row; i < first_row + n; i++) begin
            if (arr_port.size() == 0) begin
                other_errors++;
                $display("timeout, flit of row %0d never left the router", i);
            end else begin
                got_port = arr_port.pop_front();
                got_flit = arr_flit.pop_front();
                check_port("send_o port", got_port, rows[i].dst);
                check_flit("data_o", got_flit, rows[i].exp);
            end
        end
    endtask

    initial begin
        reset        = 1'b1;
        send_i       = '0;
        ready_i      = '1;
        value_errors = 0;
        other_errors = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            data_i[p] = '0;
        end
        void'($urandom(33));
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_vec("send_o", send_o, '0);
        check_vec("ready_o", ready_o, '1);

        // ====================
        // round robin on RIGHT, fresh pointers
        // ====================
        for (int p = 0; p < NUM_PORTS; p++) begin
            add_row(port_e'(3'(p)), 2, 0);
        end
        rr_vc = (polarity_o == VC_EVEN) ? VC_ODD : VC_EVEN;
        inject(0, 5);
        score(0, 5, 40);
        // pointer wrapped past PE back to UP
        add_row(PORT_UP, 1, -2);
        add_row(PORT_LEFT, 3, 1);
        // second burst goes into the channel of the first one
        cycles = 0;
        while (polarity_o == rr_vc && cycles < 2) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        inject(5, 2);
        score(5, 2, 20);

        // ====================
        // XY routing and PE delivery, one flit at a time at minimum latency
        // ====================
        first = rows.size();
        add_row(PORT_UP, -3, 2);
        add_row(PORT_DOWN, 5, -1);
        add_row(PORT_LEFT, 0, -4);
        add_row(PORT_RIGHT, 0, 7);
        add_row(PORT_PE, -8, 0);
        add_row(PORT_PE, 0, -1);
        add_row(PORT_UP, 0, 0);
        add_row(PORT_DOWN, 0, 0);
        add_row(PORT_LEFT, 0, 0);
        add_row(PORT_RIGHT, 0, 0);
        for (int i = first; i < rows.size(); i++) begin
            inject(i, 1);
            score(i, 1, 2);
        end

        // ====================
        // back-pressure, four flits from DOWN fill both channels toward RIGHT
        // ====================
        first = rows.size();
        for (int i = 0; i < 4; i++) begin
            add_row(PORT_DOWN, 1 + i, 3);
        end
        ready_i[PORT_RIGHT] = 1'b0;
        bp_vc = (polarity_o == VC_EVEN) ? VC_ODD : VC_EVEN;
        for (int i = first; i < first + 4; i++) begin
            inject(i, 1);
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            if (ready_o[PORT_DOWN]) begin
                other_errors++;
                $display("ready_o of DOWN went high while RIGHT was blocked");
            end
        end
        if (arr_port.size() != 0) begin
            other_errors++;
            $display("a flit left the router while RIGHT was blocked");
        end
        // release while the oldest flit's channel faces the link
        cycles = 0;
        while (polarity_o == bp_vc && cycles < 2) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ready_i[PORT_RIGHT] = 1'b1;
        score(first, 4, 20);

        // ====================
        // random flits to distinct outputs on consecutive edges, both channels busy
        // ====================
        first = rows.size();
        add_row(port_e'(3'($urandom % 5)), 0, -(1 + int'($urandom % 7)));
        add_row(port_e'(3'($urandom % 5)), 0, 1 + int'($urandom % 7));
        add_row(port_e'(3'($urandom % 5)), -(1 + int'($urandom % 7)), int'($urandom % 16));
        add_row(port_e'(3'($urandom % 5)), 1 + int'($urandom % 7), int'($urandom % 16));
        add_row(port_e'(3'($urandom % 5)), 0, 0);
        for (int i = first; i < first + 5; i++) begin
            inject(i, 1);
        end
        score(first, 5, 12);

        repeat (4) @(posedge clk);
        if (arr_port.size() != 0) begin
            other_errors++;
            $display("%0d flits left the router that were never sent", arr_port.size());
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
verilog/router_pkg.sv
verilog/input_vc_buffer.sv
verilog/rr_arbiter.sv
verilog/vc_switch_alloc.sv
verilog/output_vc_buffer.sv
verilog/mesh_router.sv
tests/mesh_router_assert.sv
tests/mesh_router_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the mesh router testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module mesh_router_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vmesh_router_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
exit 1
